//--- compile.f
source/op_pkg.sv
source/op_logsin.sv
source/op_exp.sv
source/op_top.sv
verif/op_asserts.sv
verif/op_tb.sv

//--- Makefile
obj_dir/Vop_tb: compile.f source/op_pkg.sv source/op_logsin.sv source/op_exp.sv \
		source/op_top.sv verif/op_asserts.sv verif/op_tb.sv
	verilator --binary --timing --assert --top-module op_tb -f compile.f

.PHONY: run clean

run: obj_dir/Vop_tb
	@out="$$(./obj_dir/Vop_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

//--- verif/op_tb.sv
`timescale 1ns/1ns
`default_nettype none

module op_tb;

	import op_pkg::*;

	localparam int LATENCY = 5;
	localparam int TIMEOUT = 50;

	// Row bit positions per sub-range, MSB first. A -1 stands for a zero bit.
	// Log-sine base at 0, log-sine delta at 44, mantissa at 76, mantissa delta at 116.
	localparam int POS_TAB [128] = '{
		45, 44, 42, 40, 36, 32, 27, 22, 17, 11, 4,
		-1, -1, 43, 41, 37, 33, 28, 23, 18, 12, 5,
		-1, -1, -1, -1, 38, 34, 29, 24, 19, 13, 6,
		-1, -1, -1, -1, -1, -1, 30, 25, 20, 14, 7,
		39, 35, 31, 26, 21, 15, 8, 0, -1, -1, -1, -1, -1, 16, 9, 1,
		-1, -1, -1, -1, -1, -1, 10, 2, -1, -1, -1, -1, -1, -1, -1, 3,
		-1, -1, 39, 35, 31, 27, 23, 15, 8, 0,
		-1, 43, 40, 36, 32, 28, 24, 16, 9, 1,
		46, 44, 41, 37, 33, 29, 25, 17, 10, 2,
		47, 45, 42, 38, 34, 30, 26, 18, 11, 3,
		19, 12, 4, 20, 13, 5, 21, -1, 6, 22, 14, 7
	};

	logic mclk_i;
	logic arst_n_i;
	logic [PHASE_W-1:0] phase_i;
	logic [ATT_W-1:0] eg_att_i;
	wire [OUT_W-1:0] out_o;

	logic [OUT_W-1:0] exp_q [$];
	logic [OUT_W-1:0] obs_q [$];
	logic [OUT_W-1:0] exp_v;
	logic [OUT_W-1:0] sweep_out [1024];
	int n_in = 0;
	int seed;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_errs;
	string test_name;

	op_top dut_i
	(
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.phase_i(phase_i),
		.eg_att_i(eg_att_i),
		.out_o(out_o)
	);

	initial
	begin
		mclk_i = 1'b0;
		forever #10 mclk_i = ~mclk_i;
	end

	// ========================================
	// Reference model
	// ========================================
	function automatic logic [10:0] gather(input logic [47:0] row, input int start, input int n);
		logic [10:0] v;
		int i;
		int p;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			p = POS_TAB[7'(start + i)];
			v = {v[9:0], (p >= 0) ? row[p[5:0]] : 1'b0};
		end
		return v;
	endfunction

	function automatic logic [OUT_W-1:0] ref_out(input logic [PHASE_W-1:0] phase,
		input logic [ATT_W-1:0] att);
		logic [7:0] idx;
		logic [47:0] row;
		logic [10:0] base;
		logic [7:0] delta;
		logic [LOG_W-1:0] log_val;
		logic [SUM_W-1:0] sum;
		logic [11:0] ein;
		logic [MANT_W-1:0] mant;
		logic [12:0] mag;
		int g;
		idx = phase[8] ? ~phase[7:0] : phase[7:0];
		g = int'(idx[7:6]);
		row = {2'b00, LOGSIN_ROM[idx[5:1]]};
		base = gather(row, g * 11, 11);
		delta = idx[0] ? 8'h00 : 8'(gather(row, 44 + g * 8, 8));
		log_val = {1'b0, base} + {{4{delta[7]}}, delta};
		sum = {1'b0, log_val} + {1'b0, att, 2'b00};
		// Saturated sum inverts to zero.
		ein = sum[12] ? 12'h000 : ~sum[11:0];
		g = int'(ein[7:6]);
		row = EXP_ROM[ein[5:1]];
		mant = 10'(gather(row, 76 + g * 10, 10));
		if (ein[0])
			mant = mant + 10'(gather(row, 116 + g * 3, 3));
		mag = {1'b1, mant, 2'b00} >> (4'd15 - ein[11:8]);
		return phase[9] ? -{1'b0, mag} : {1'b0, mag};
	endfunction

	function automatic logic [OUT_W-1:0] magnitude(input logic [OUT_W-1:0] v);
		return v[OUT_W-1] ? -v : v;
	endfunction

	// ========================================
	// Checking and stimulus
	// ========================================
	task automatic compare(input string name, input logic [OUT_W-1:0] expv,
		input logic [OUT_W-1:0] got);
		checks++;
		assert (got == expv)
		else
		begin
			$display("[FAIL] %s expected %h got %h", name, expv, got);
			errors++;
		end
	endtask

	// Output sampled here is the slot taken five edges earlier.
	always @(posedge mclk_i)
	begin
		if (arst_n_i)
		begin
			if (exp_q.size() == LATENCY)
			begin
				exp_v = exp_q.pop_front();
				compare("out_o", exp_v, out_o);
				obs_q.push_back(out_o);
			end
			exp_q.push_back(ref_out(phase_i, eg_att_i));
			n_in++;
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_errs = errors;
		tests++;
	endtask

	task automatic end_test;
		if (errors == test_errs)
			$display("test %s: ok", test_name);
		else
		begin
			$display("test %s: %0d errors", test_name, errors - test_errs);
			failed_tests++;
		end
	endtask

	task automatic drive(input logic [PHASE_W-1:0] ph, input logic [ATT_W-1:0] at,
		output int slot);
		@(negedge mclk_i);
		phase_i = ph;
		eg_att_i = at;
		slot = n_in;
	endtask

	task automatic wait_out(input int slot, output logic [OUT_W-1:0] val);
		int t;
		t = 0;
		while (obs_q.size() <= slot && t < TIMEOUT)
		begin
			@(negedge mclk_i);
			t++;
		end
		if (obs_q.size() <= slot)
		begin
			$display("Timeout: no output for slot %0d within %0d cycles", slot, TIMEOUT);
			$display("FAIL: see errors above");
			$finish;
		end
		else
			val = obs_q[slot];
	endtask

	initial
	begin
		int slot;
		int first;
		int k;
		logic [31:0] r;
		logic [OUT_W-1:0] o1;
		logic [OUT_W-1:0] o2;
		seed = 32'h4976_089e;
		arst_n_i = 1'b1;
		phase_i = '0;
		eg_att_i = '0;
		#1;
		arst_n_i = 1'b0;

		start_test("reset");
		repeat (4)
		begin
			@(negedge mclk_i);
			compare("out_o", '0, out_o);
		end
		arst_n_i = 1'b1;
		repeat (LATENCY)
		begin
			compare("out_o", '0, out_o);
			@(negedge mclk_i);
		end
		end_test();

		start_test("sweep");
		first = 0;
		for (k = 0; k < 1024; k++)
		begin
			drive(10'(k), '0, slot);
			if (k == 0)
				first = slot;
		end
		wait_out(slot, o1);
		for (k = 0; k < 1024; k++)
			sweep_out[10'(k)] = obs_q[first + k];
		end_test();

		start_test("symmetry");
		for (k = 0; k < 1024; k++)
		begin
			compare("out_o", sweep_out[10'(k)], sweep_out[10'(k ^ 'h1ff)]);
			if (k < 512)
				compare("out_o", -sweep_out[10'(k)], sweep_out[10'(k + 512)]);
		end
		end_test();

		// Attenuation stays small enough that no sum overflows.
		start_test("octave");
		for (k = 0; k < 64; k++)
		begin
			r = $random(seed);
			drive(r[9:0], {2'b00, r[17:10]}, first);
			drive(r[9:0], {2'b00, r[17:10]} + 10'd64, slot);
			wait_out(slot, o2);
			o1 = obs_q[first];
			compare("|out_o|", magnitude(o1) >> 1, magnitude(o2));
		end
		end_test();

		start_test("clamp");
		for (k = 0; k < 1024; k++)
		begin
			drive(10'(k), 10'h3ff, slot);
			if (k == 0)
				first = slot;
		end
		wait_out(slot, o1);
		for (k = 0; k < 1024; k++)
			compare("out_o", '0, obs_q[first + k]);
		end_test();

		start_test("random");
		for (k = 0; k < 500; k++)
		begin
			r = $random(seed);
			drive(r[9:0], r[25:16], slot);
		end
		wait_out(slot, o1);
		end_test();

		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d, assertion failures: %0d",
			tests, failed_tests, checks, errors, dut_i.u_asserts.fail_count);
		if (errors == 0 && dut_i.u_asserts.fail_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/op_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module op_asserts
(
	input wire mclk_i,
	input wire arst_n_i,
	input wire [op_pkg::ATT_W-1:0] eg_att_i,
	input wire [op_pkg::OUT_W-1:0] out_o
);

	int fail_count = 0;

	reset_clear: assert property (@(posedge mclk_i) !arst_n_i |-> out_o == '0)
	else
	begin
		$error("out_o not zero during reset");
		fail_count++;
	end

	// Magnitude fits in 13 bits, so the most negative code never shows.
	no_min_code: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		out_o != 14'h2000)
	else
	begin
		$error("out_o reached the most negative code");
		fail_count++;
	end

	// Five slots without attenuation give a non-zero sample.
	live_output: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		(eg_att_i == '0 && $past(eg_att_i, 1) == '0 && $past(eg_att_i, 2) == '0
		&& $past(eg_att_i, 3) == '0 && $past(eg_att_i, 4) == '0 && $past(arst_n_i, 4))
		|=> out_o != '0)
	else
	begin
		$error("out_o stayed zero after five slots without attenuation");
		fail_count++;
	end

endmodule

bind op_top op_asserts u_asserts
(
	.mclk_i(mclk_i),
	.arst_n_i(arst_n_i),
	.eg_att_i(eg_att_i),
	.out_o(out_o)
);

`default_nettype wire

//--- source/op_top.sv
`timescale 1ns/1ns
`default_nettype none

module op_top
(
	input wire mclk_i,
	input wire arst_n_i,
	input wire [op_pkg::PHASE_W-1:0] phase_i,
	input wire [op_pkg::ATT_W-1:0] eg_att_i,
	output wire [op_pkg::OUT_W-1:0] out_o
);

	import op_pkg::*;

	logic [LOG_W-1:0] log_att;
	logic neg;

	// Phase to log attenuation, two cycles.
	op_logsin u_logsin
	(
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.phase_i(phase_i),
		.log_att_o(log_att),
		.neg_o(neg)
	);

	// Envelope add, exponent and sign, three more cycles.
	op_exp u_exp
	(
		.mclk_i(mclk_i),
		.arst_n_i(arst_n_i),
		.eg_att_i(eg_att_i),
		.log_att_i(log_att),
		.neg_i(neg),
		.out_o(out_o)
	);

endmodule

`default_nettype wire

//--- source/op_exp.sv
`timescale 1ns/1ns
`default_nettype none

module op_exp
(
	input wire mclk_i,
	input wire arst_n_i,
	input wire [op_pkg::ATT_W-1:0] eg_att_i,
	input wire [op_pkg::LOG_W-1:0] log_att_i,
	input wire neg_i,
	output logic [op_pkg::OUT_W-1:0] out_o
);

	import op_pkg::*;

	logic [ATT_W-1:0] att_q1;
	logic [ATT_W-1:0] att_q2;
	logic [SUM_W-1:0] sum_q;
	logic [LOG_W-1:0] exp_in;
	logic [EXP_ROW_W-1:0] exp_row;
	logic [12:0] exp_sel;
	logic [12:0] exp_sel_q;
	logic exp_idx0_q;
	logic [3:0] shift_q;
	logic neg_q3;
	logic neg_q4;
	logic [2:0] mant_delta;
	logic [MANT_W-1:0] mant;
	logic [12:0] mag;
	logic [OUT_W-1:0] out_d;

	// ========================================
	// Attenuation add
	// ========================================
	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			att_q1 <= '1;
			att_q2 <= '1;
			sum_q <= '1;
		end
		else
		begin
			att_q1 <= eg_att_i;
			att_q2 <= att_q1;
			sum_q <= {1'b0, log_att_i} + {1'b0, att_q2, 2'b00};
		end
	end

	// Overflow saturates to full attenuation.
	assign exp_in = ~(sum_q[SUM_W-1] ? {LOG_W{1'b1}} : sum_q[LOG_W-1:0]);
	assign exp_row = EXP_ROM[exp_in[5:1]];

	// ========================================
	// Exponent table
	// ========================================
	always_comb
	begin
		case (exp_in[7:6])
			2'd0: exp_sel = {2'b00, exp_row[39], exp_row[35], exp_row[31], exp_row[27],
				exp_row[23], exp_row[19], exp_row[15], exp_row[12], exp_row[8], exp_row[4],
				exp_row[0]};
			2'd1: exp_sel = {1'b0, exp_row[43], exp_row[40], exp_row[36], exp_row[32],
				exp_row[28], exp_row[24], exp_row[20], exp_row[16], exp_row[13], exp_row[9],
				exp_row[5], exp_row[1]};
			2'd2: exp_sel = {exp_row[46], exp_row[44], exp_row[41], exp_row[37], exp_row[33],
				exp_row[29], exp_row[25], exp_row[21], exp_row[17], 1'b0, exp_row[10],
				exp_row[6], exp_row[2]};
			default: exp_sel = {exp_row[47], exp_row[45], exp_row[42], exp_row[38],
				exp_row[34], exp_row[30], exp_row[26], exp_row[22], exp_row[18], exp_row[14],
				exp_row[11], exp_row[7], exp_row[3]};
		endcase
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			exp_sel_q <= '0;
			exp_idx0_q <= 1'b0;
			shift_q <= '0;
			neg_q3 <= 1'b0;
			neg_q4 <= 1'b0;
		end
		else
		begin
			exp_sel_q <= exp_sel;
			exp_idx0_q <= exp_in[0];
			shift_q <= exp_in[11:8];
			neg_q3 <= neg_i;
			neg_q4 <= neg_q3;
		end
	end

	// Delta only on odd entries.
	assign mant_delta = exp_idx0_q ? {exp_sel_q[5], exp_sel_q[3], exp_sel_q[1]} : 3'b000;
	assign mant = {exp_sel_q[12:6], exp_sel_q[4], exp_sel_q[2], exp_sel_q[0]}
		+ {7'd0, mant_delta};

	// Implied leading one; e = 15 leaves it unshifted.
	assign mag = {1'b1, mant, 2'b00} >> (4'd15 - shift_q);
	assign out_d = neg_q4 ? -{1'b0, mag} : {1'b0, mag};

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			out_o <= '0;
		else
			out_o <= out_d;
	end

endmodule

`default_nettype wire

//--- source/op_logsin.sv
`timescale 1ns/1ns
`default_nettype none

module op_logsin
(
	input wire mclk_i,
	input wire arst_n_i,
	input wire [op_pkg::PHASE_W-1:0] phase_i,
	output logic [op_pkg::LOG_W-1:0] log_att_o,
	output logic neg_o
);

	import op_pkg::*;

	logic [PHASE_W-1:0] phase_q;
	logic [7:0] sin_idx;
	logic [LOGSIN_ROW_W-1:0] sin_row;
	logic [18:0] sin_sel;
	logic [18:0] sin_sel_q;
	logic idx0_q;
	logic [10:0] sin_base;
	logic [7:0] sin_delta;

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			phase_q <= '0;
		else
			phase_q <= phase_i;
	end

	// Second quarter mirrors the first.
	assign sin_idx = phase_q[7:0] ^ {8{phase_q[8]}};
	assign sin_row = LOGSIN_ROM[sin_idx[5:1]];

	// Pick the sub-range bits, unused positions read as zero.
	always_comb
	begin
		case (sin_idx[7:6])
			2'd0: sin_sel = {sin_row[45], sin_row[44], sin_row[42], sin_row[40], sin_row[39],
				sin_row[36], sin_row[35], sin_row[32], sin_row[31], sin_row[27], sin_row[26],
				sin_row[22], sin_row[21], sin_row[17], sin_row[15], sin_row[11], sin_row[8],
				sin_row[4], sin_row[0]};
			2'd1: sin_sel = {2'b00, sin_row[43], sin_row[41], 1'b0, sin_row[37], 1'b0,
				sin_row[33], 1'b0, sin_row[28], 1'b0, sin_row[23], 1'b0, sin_row[18],
				sin_row[16], sin_row[12], sin_row[9], sin_row[5], sin_row[1]};
			2'd2: sin_sel = {5'b00000, sin_row[38], 1'b0, sin_row[34], 1'b0, sin_row[29], 1'b0,
				sin_row[24], 1'b0, sin_row[19], 1'b0, sin_row[13], sin_row[10], sin_row[6],
				sin_row[2]};
			default: sin_sel = {9'b000000000, sin_row[30], 1'b0, sin_row[25], 1'b0, sin_row[20],
				1'b0, sin_row[14], 1'b0, sin_row[7], sin_row[3]};
		endcase
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			sin_sel_q <= '0;
			idx0_q <= 1'b0;
			neg_o <= 1'b0;
		end
		else
		begin
			sin_sel_q <= sin_sel;
			idx0_q <= sin_idx[0];
			neg_o <= phase_q[9];
		end
	end

	// Odd bits carry the base, even bits the delta.
	assign sin_base = {sin_sel_q[18:15], sin_sel_q[13], sin_sel_q[11], sin_sel_q[9],
		sin_sel_q[7], sin_sel_q[5], sin_sel_q[3], sin_sel_q[1]};
	assign sin_delta = idx0_q ? 8'h00 : {sin_sel_q[14], sin_sel_q[12], sin_sel_q[10],
		sin_sel_q[8], sin_sel_q[6], sin_sel_q[4], sin_sel_q[2], sin_sel_q[0]};

	assign log_att_o = {1'b0, sin_base} + {{(LOG_W-8){sin_delta[7]}}, sin_delta};

endmodule

`default_nettype wire

//--- source/op_pkg.sv
`default_nettype none

package op_pkg;

	// ========================================
	// Data path widths
	// ========================================
	localparam int PHASE_W = 10;
	localparam int ATT_W = 10;
	localparam int LOG_W = 12;
	localparam int SUM_W = 13;
	localparam int MANT_W = 10;
	localparam int OUT_W = 14;

	// ========================================
	// Table geometry
	// ========================================
	localparam int ROM_DEPTH = 32;
	localparam int LOGSIN_ROW_W = 46;
	localparam int EXP_ROW_W = 48;

	// Log-sine rows, row 31 first.
	// Four sub-ranges share a row, base and delta bits interleaved.
	localparam logic [ROM_DEPTH-1:0][LOGSIN_ROW_W-1:0] LOGSIN_ROM = {
		46'b0001100001000100100001000010101010101000100101,
		46'b0001100001010100001000000001001001001100010100,
		46'b0001100001010100001000110000101011001100000110,
		46'b0001110000010000000000110011001001001100100111,
		46'b0001110000010000011000000011101010001110010110,
		46'b0001110000010100010001100000001000101110100111,
		46'b0001110000010100011001100001001011001110100101,
		46'b0001110000011100001001010011101000101111001111,
		46'b0001110001011000000001110010101110001101110111,
		46'b0001110001011000101000111001100101011001101010,
		46'b0001110001011100110000011011100100001010100111,
		46'b0001110001011100111000111110100011001001110111,
		46'b0100100010010000100001011100100000111001111011,
		46'b0100100010010100100001001111000001111110100010,
		46'b0100100010010100101001101111110110100101100100,
		46'b0100100111000000010000011101000110101110010111,
		46'b0100100111000100010000101110001101001011111110,
		46'b0100100111001100001011011000001001011000011011,
		46'b0100110110001000001011101000001010111011111011,
		46'b0100110110001100010011011010111110110100011000,
		46'b0100110111001000110010111100101010001100010111,
		46'b0100110111001100110110110111110001010111110000,
		46'b0111000100000000101111000101010101010101111001,
		46'b0111000100000100101111110111011101010010111011,
		46'b0111000101010101010100101000110000010010010001,
		46'b0111010100011001001100011010011100010000101001,
		46'b0111010101011011001001100100010000110100110010,
		46'b1010000100011011011001011110010001110010101001,
		46'b1010000101011111111100100101011100010010010011,
		46'b1010010111110101100010001011110001010100001010,
		46'b1011010110110011110111011000011100110000011010,
		46'b1110011111010001110111100110011001110101111010
	};

	// Exponent rows, row 31 first.
	// Sub-range 0 has no top mantissa bits, they come from the implied one.
	localparam logic [ROM_DEPTH-1:0][EXP_ROW_W-1:0] EXP_ROM = {
		48'b111011111100011111101000111101000001000110011101,
		48'b111011111100011010011111011000001011100010110011,
		48'b111011111100000011110110111101101001110111011010,
		48'b111011111100000011100001111101100101000001010110,
		48'b111011111100000010000110011100100101000001011011,
		48'b111011101001010101011101111101000001111111011101,
		48'b111011001011011101111010011111001000011011000000,
		48'b111011001011011100100101111100001001001111011110,
		48'b111011001011001101000110111101000001101011011010,
		48'b111011001011000001110011011101110001010111010100,
		48'b111011000011100010111100111100110001110110010101,
		48'b111010000111110011001111011101111001110010011011,
		48'b111010000111110011000000111001111011001110111101,
		48'b111010000100111110110111111100110101101001010001,
		48'b111010000100111110110000011100110001001110010011,
		48'b111010000100101101011010111101001001110011010101,
		48'b111010000100101100001101011001001011010110110111,
		48'b111010000100100100101010011000000011111010110001,
		48'b111010000000110001110101111000000011011110110011,
		48'b111010000000110000010110011001011011100011110101,
		48'b111010000000010010001001111101011001000110010101,
		48'b101110100010001011101110111000010011101010110101,
		48'b101100110011001111111001011000010011001111110011,
		48'b101100110011001110010011111001001011100010110001,
		48'b100101110111011111010100111001000011000010101010,
		48'b100101110111010111100011011000000011101110111000,
		48'b100101110111010100101100111100001001001010011010,
		48'b100101110111010000011011011100011001000110010000,
		48'b100101110111000001011000011001010011101010110001,
		48'b100101110101001000100111111001010011001110111011,
		48'b100101110101001000100001011101001001000100000000,
		48'b100101110001011001000110011000000011101010110000
	};

endpackage

`default_nettype wire
